// ==== common/issue_defines.svh ====
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// architectural register count, r0 included
`define NUM_REGS 32

// words in the exec scratch memory
// indexed by address bits above the byte offset
`define SCRATCH_WORDS 16

// width of the opcode field in a decoded slot
`define OP_W 4

`endif

// ==== common/issue_pkg.sv ====
`include "issue_defines.svh"

package issue_pkg;

    // widths with a meaning
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;
    typedef logic [31:0] word_t;
    typedef logic [$clog2(`SCRATCH_WORDS)-1:0] scratch_idx_t;

    typedef enum logic [`OP_W-1:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LUI,
        OP_LD,
        OP_ST
    } op_t;

    // one decoded instruction
    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        word_t    imm;
    } slot_t;

    // memory ops only ever sit in slot0
    typedef struct packed {
        slot_t slot1;
        slot_t slot0;
    } issue_pair_t;

    typedef struct packed {
        word_t rj_data;
        word_t rk_data;
    } operand_t;

    typedef struct packed {
        issue_pair_t pair;
        operand_t    operand0;
        operand_t    operand1;
    } ex_pair_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

// ==== list.f ====
+incdir+common
common/issue_pkg.sv
reg_read/regfile.sv
reg_read/load_use_guard.sv
reg_read/reg_read_stage.sv
rtl/exec_stage.sv
rtl/issue_core.sv
testbench/issue_core_properties.sv
testbench/issue_core_tb.sv

// ==== reg_read/load_use_guard.sv ====
`timescale 1ns/1ps

module load_use_guard
    import issue_pkg::*;
(
    input  logic     clk,
    input  logic     aresetn,
    input  logic     ex_fire,
    input  op_t      held_op,
    input  reg_idx_t held_rd,
    input  reg_idx_t src [4],
    input  logic     hold_load,
    output logic     hazard
);

    // destinations of loads still walking the load pipe
    // entry 0 is address stage, entry 1 is data stage
    reg_idx_t hist [2];
    reg_idx_t held_load_rd;

    // zero when the held slot0 is not a load
    assign held_load_rd = (held_op == OP_LD) ? held_rd : '0;

    // advances in step with the load pipe, bubbles shift in as r0
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            hist[0] <= '0;
            hist[1] <= '0;
        end else if (!hold_load) begin
            hist[1] <= hist[0];
            hist[0] <= ex_fire ? held_load_rd : '0;
        end
    end

    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (src[i] != '0 &&
                (src[i] == held_load_rd || src[i] == hist[0] || src[i] == hist[1])) begin
                hazard = 1'b1;
            end
        end
    end

endmodule

// ==== reg_read/reg_read_stage.sv ====
`timescale 1ns/1ps

module reg_read_stage
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        in_valid,
    input  issue_pair_t in_pair,
    output logic        in_ready,
    input  wb_t         wb [3],
    input  logic        allowin,
    output logic        readygo,
    output ex_pair_t    ex_pair
);

    reg_idx_t raddr [4];
    word_t    rdata [4];
    logic     stage_valid;
    ex_pair_t stage_q;
    logic     out_of_reset;
    logic     hazard;
    logic     accept;
    logic     ex_fire;
    op_t      held_op;

    // source order rj0, rk0, rj1, rk1
    assign raddr[0] = in_pair.slot0.rj;
    assign raddr[1] = in_pair.slot0.rk;
    assign raddr[2] = in_pair.slot1.rj;
    assign raddr[3] = in_pair.slot1.rk;

    regfile regfile_i (
        .clk     (clk),
        .aresetn (aresetn),
        .raddr   (raddr),
        .rdata   (rdata),
        .wb      (wb)
    );

    // invalid stage must not look like a pending load
    assign held_op = stage_valid ? stage_q.pair.slot0.op : OP_NOP;

    load_use_guard load_use_guard_i (
        .clk       (clk),
        .aresetn   (aresetn),
        .ex_fire   (ex_fire),
        .held_op   (held_op),
        .held_rd   (stage_q.pair.slot0.rd),
        .src       (raddr),
        .hold_load (!allowin),
        .hazard    (hazard)
    );

    // keeps in_ready low through the first edge after reset
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
        end
    end

    assign readygo  = stage_valid;
    assign ex_fire  = readygo && allowin;
    assign in_ready = out_of_reset && (allowin || !stage_valid) && !hazard && !flush;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            // pair leaves anyway if exec takes it this edge
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (ex_fire) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_q.pair             <= in_pair;
            stage_q.operand0.rj_data <= rdata[0];
            stage_q.operand0.rk_data <= rdata[1];
            stage_q.operand1.rj_data <= rdata[2];
            stage_q.operand1.rk_data <= rdata[3];
        end
    end

    assign ex_pair = stage_q;

endmodule

// ==== reg_read/regfile.sv ====
`timescale 1ns/1ps
`include "issue_defines.svh"

module regfile
    import issue_pkg::*;
(
    input  logic     clk,
    input  logic     aresetn,
    input  reg_idx_t raddr [4],
    output word_t    rdata [4],
    input  wb_t      wb [3]
);

    word_t regs [`NUM_REGS];

    // three write ports, later port wins on the same rd
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < 3; p++) begin
                // r0 is never written, so it stays zero from reset
                if (wb[p].we && wb[p].rd != '0) begin
                    regs[wb[p].rd] <= wb[p].data;
                end
            end
        end
    end

    // write-first read
    // a write landing at the next edge is visible this cycle
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata[i] = regs[raddr[i]];
            for (int p = 0; p < 3; p++) begin
                if (wb[p].we && wb[p].rd == raddr[i]) begin
                    rdata[i] = wb[p].data;
                end
            end
            if (raddr[i] == '0) begin
                rdata[i] = '0;
            end
        end
    end

endmodule

// ==== rtl/exec_stage.sv ====
`timescale 1ns/1ps
`include "issue_defines.svh"

module exec_stage
    import issue_pkg::*;
(
    input  logic     clk,
    input  logic     aresetn,
    input  logic     ex_hold,
    input  logic     readygo,
    input  ex_pair_t ex_pair,
    output logic     allowin,
    output wb_t      wb [3]
);

    function automatic word_t alu(op_t op, word_t a, word_t b, word_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_LUI:  return imm;
            default: return '0;
        endcase
    endfunction

    function automatic logic is_alu(op_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI};
    endfunction

    slot_t        s0;
    slot_t        s1;
    logic         ex_fire;
    word_t        ls_addr;
    scratch_idx_t ls_idx;
    word_t        scratch [`SCRATCH_WORDS];

    // load pipe, address stage then data stage
    logic         a_valid;
    reg_idx_t     a_rd;
    scratch_idx_t a_idx;
    logic         d_valid;
    reg_idx_t     d_rd;
    word_t        d_data;

    assign s0      = ex_pair.pair.slot0;
    assign s1      = ex_pair.pair.slot1;
    assign allowin = !ex_hold;
    assign ex_fire = readygo && allowin;

    // word index from byte address
    assign ls_addr = ex_pair.operand0.rj_data + s0.imm;
    assign ls_idx  = ls_addr[2 +: $bits(scratch_idx_t)];

    always_comb begin
        wb[0].we   = ex_fire && is_alu(s0.op) && s0.rd != '0;
        wb[0].rd   = s0.rd;
        wb[0].data = alu(s0.op, ex_pair.operand0.rj_data, ex_pair.operand0.rk_data, s0.imm);
        wb[1].we   = ex_fire && is_alu(s1.op) && s1.rd != '0;
        wb[1].rd   = s1.rd;
        wb[1].data = alu(s1.op, ex_pair.operand1.rj_data, ex_pair.operand1.rk_data, s1.imm);
        // held load result waits for ex_hold to drop
        wb[2].we   = d_valid && !ex_hold;
        wb[2].rd   = d_rd;
        wb[2].data = d_data;
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int w = 0; w < `SCRATCH_WORDS; w++) begin
                scratch[w] <= '0;
            end
        end else if (ex_fire && s0.op == OP_ST) begin
            scratch[ls_idx] <= ex_pair.operand0.rk_data;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            a_valid <= 1'b0;
            d_valid <= 1'b0;
        end else if (!ex_hold) begin
            a_valid <= ex_fire && s0.op == OP_LD && s0.rd != '0;
            d_valid <= a_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_hold) begin
            a_rd   <= s0.rd;
            a_idx  <= ls_idx;
            d_rd   <= a_rd;
            d_data <= scratch[a_idx];
        end
    end

endmodule

// ==== rtl/issue_core.sv ====
`timescale 1ns/1ps

module issue_core
    import issue_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        ex_hold,
    input  logic        in_valid,
    input  issue_pair_t in_pair,
    output logic        in_ready,
    output wb_t         wb [3]
);

    logic     allowin;
    logic     readygo;
    ex_pair_t ex_pair;

    // register read and hazard stall
    reg_read_stage reg_read_stage_i (
        .clk      (clk),
        .aresetn  (aresetn),
        .flush    (flush),
        .in_valid (in_valid),
        .in_pair  (in_pair),
        .in_ready (in_ready),
        .wb       (wb),
        .allowin  (allowin),
        .readygo  (readygo),
        .ex_pair  (ex_pair)
    );

    // alu slots and load/store pipe, writes loop back to the regfile
    exec_stage exec_stage_i (
        .clk     (clk),
        .aresetn (aresetn),
        .ex_hold (ex_hold),
        .readygo (readygo),
        .ex_pair (ex_pair),
        .allowin (allowin),
        .wb      (wb)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the issue_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module issue_core_tb -o issue_core_sim

# assertion failures must not stop the run before the verdict line
output=$(./obj_dir/issue_core_sim +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -qx "Simulation PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// ==== testbench/issue_core_properties.sv ====
`timescale 1ns/1ps

module issue_core_properties
    import issue_pkg::*;
(
    input logic        clk,
    input logic        aresetn,
    input logic        flush,
    input issue_pair_t in_pair,
    input logic        in_ready,
    input logic        allowin,
    input logic        readygo,
    input ex_pair_t    stage_q
);

    int       fail_count = 0;
    reg_idx_t held_rd;
    logic     held_load;
    logic     src_hit;

    assign held_rd   = stage_q.pair.slot0.rd;
    assign held_load = readygo && stage_q.pair.slot0.op == OP_LD && held_rd != '0;
    assign src_hit   = in_pair.slot0.rj == held_rd || in_pair.slot0.rk == held_rd ||
                       in_pair.slot1.rj == held_rd || in_pair.slot1.rk == held_rd;

    // flushed pair is gone one cycle later
    flush_empties: assert property (@(posedge clk) disable iff (!aresetn)
        flush |=> !readygo)
        else begin
            fail_count = fail_count + 1;
            $error("stage still valid the cycle after a flush");
        end

    load_use_stall: assert property (@(posedge clk) disable iff (!aresetn)
        held_load && src_hit |-> !in_ready)
        else begin
            fail_count = fail_count + 1;
            $error("pair accepted while a source waits on the held load");
        end

    // back-pressure keeps the pair and its operands
    hold_keeps_pair: assert property (@(posedge clk) disable iff (!aresetn)
        readygo && !allowin && !flush |=> readygo && $stable(stage_q))
        else begin
            fail_count = fail_count + 1;
            $error("held pair changed under back-pressure");
        end

endmodule

bind reg_read_stage issue_core_properties props_i (
    .clk      (clk),
    .aresetn  (aresetn),
    .flush    (flush),
    .in_pair  (in_pair),
    .in_ready (in_ready),
    .allowin  (allowin),
    .readygo  (readygo),
    .stage_q  (stage_q)
);

// ==== testbench/issue_core_tb.sv ====
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_core_tb
    import issue_pkg::*;
();

    localparam int NUM_PAIRS   = 400;
    localparam int CYCLE_LIMIT = NUM_PAIRS * 4 + 50;

    logic        clk;
    logic        aresetn;
    logic        flush;
    logic        ex_hold;
    logic        in_valid;
    issue_pair_t in_pair;
    logic        in_ready;
    wb_t         wb [3];

    // reference state, pair in the stage plus architectural state
    word_t       m_regs [`NUM_REGS];
    word_t       m_scratch [`SCRATCH_WORDS];
    logic        m_valid;
    issue_pair_t m_pair;
    wb_t         exp_alu0 [$];
    wb_t         exp_alu1 [$];
    wb_t         exp_load [$];

    logic [31:0] lfsr_state;
    reg_idx_t    last_ld_rd;
    logic        took_pair;
    int          hold_left;
    int          accepted;
    int          cycles;
    int          value_errors;
    int          other_errors;
    int          assert_fails;

    issue_core dut_i (
        .clk      (clk),
        .aresetn  (aresetn),
        .flush    (flush),
        .ex_hold  (ex_hold),
        .in_valid (in_valid),
        .in_pair  (in_pair),
        .in_ready (in_ready),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not drain within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d value, %0d protocol", value_errors, other_errors);
        $display("Simulation FAILED");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    // low registers half the time, so pairs often depend on each other
    function automatic reg_idx_t pick_src();
        return (rand_bits(1) == 1) ? reg_idx_t'(rand_bits(3)) : reg_idx_t'(rand_bits(5));
    endfunction

    function automatic op_t pick_alu_op();
        logic [3:0] k;
        k = 4'(rand_bits(3));
        if (k == 4'd0) return OP_NOP;
        if (k == 4'd7) return OP_LUI;
        return op_t'(k);
    endfunction

    // alu results go to r0..r23, loads own r24..r31
    function automatic slot_t make_alu_slot();
        slot_t s;
        s.op  = pick_alu_op();
        s.rd  = (rand_bits(1) == 1) ? reg_idx_t'(rand_bits(3)) : reg_idx_t'(rand_bits(5) % 24);
        s.rj  = pick_src();
        s.rk  = pick_src();
        s.imm = rand_bits(32);
        return s;
    endfunction

    function automatic issue_pair_t make_pair();
        issue_pair_t p;
        logic [2:0]  kind;
        p.slot0 = make_alu_slot();
        p.slot1 = make_alu_slot();
        kind    = 3'(rand_bits(3));
        if (kind == 3'd0 || kind == 3'd1) begin
            p.slot0.op  = (kind == 3'd0) ? OP_LD : OP_ST;
            p.slot0.rd  = (kind == 3'd0) ? reg_idx_t'(24 + rand_bits(3)) : reg_idx_t'(0);
            if (rand_bits(1) == 1) begin
                p.slot0.rj = '0;
            end
            p.slot0.imm = rand_bits(6);
        end
        // consumer of the previous load
        if (last_ld_rd != '0 && rand_bits(1) == 1) begin
            p.slot1.rj = last_ld_rd;
        end
        // slot1 never reads what slot0 writes
        if (p.slot0.op != OP_ST && p.slot0.op != OP_NOP) begin
            if (p.slot1.rj == p.slot0.rd) p.slot1.rj = '0;
            if (p.slot1.rk == p.slot0.rd) p.slot1.rk = '0;
        end
        last_ld_rd = (p.slot0.op == OP_LD) ? p.slot0.rd : reg_idx_t'(0);
        return p;
    endfunction

    function automatic word_t model_alu(op_t op, word_t a, word_t b, word_t imm);
        word_t r;
        r = '0;
        if (op == OP_ADD) r = a + b;
        else if (op == OP_SUB) r = a - b;
        else if (op == OP_AND) r = a & b;
        else if (op == OP_OR) r = a | b;
        else if (op == OP_XOR) r = a ^ b;
        else if (op == OP_LUI) r = imm;
        return r;
    endfunction

    task automatic execute_slot(input slot_t s, input int port);
        word_t addr;
        wb_t   w;
        addr   = m_regs[s.rj] + s.imm;
        w.we   = 1'b1;
        w.rd   = s.rd;
        w.data = model_alu(s.op, m_regs[s.rj], m_regs[s.rk], s.imm);
        if (s.op == OP_ST) begin
            m_scratch[addr[5:2]] = m_regs[s.rk];
        end else if (s.op == OP_LD) begin
            w.data = m_scratch[addr[5:2]];
        end
        if (s.op != OP_NOP && s.op != OP_ST && s.rd != '0) begin
            m_regs[s.rd] = w.data;
            if (s.op == OP_LD) exp_load.push_back(w);
            else if (port == 0) exp_alu0.push_back(w);
            else exp_alu1.push_back(w);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, want, $time);
        end
    endtask

    task automatic match_write(input int port, input wb_t got);
        wb_t  want;
        logic found;
        found = 1'b0;
        if (port == 0 && exp_alu0.size() != 0) begin
            want  = exp_alu0.pop_front();
            found = 1'b1;
        end else if (port == 1 && exp_alu1.size() != 0) begin
            want  = exp_alu1.pop_front();
            found = 1'b1;
        end else if (port == 2 && exp_load.size() != 0) begin
            want  = exp_load.pop_front();
            found = 1'b1;
        end
        if (!found) begin
            other_errors++;
            $display("unexpected write on wb[%0d] to r%0d at %0t", port, got.rd, $time);
        end else begin
            check_value($sformatf("wb[%0d].rd", port), 32'(got.rd), 32'(want.rd));
            check_value($sformatf("wb[%0d].data", port), got.data, want.data);
        end
    endtask

    // one cycle of the model, sampled mid-cycle
    task automatic process_cycle();
        logic acc;
        logic fire;
        acc  = in_valid && in_ready;
        fire = m_valid && !ex_hold;
        if (accepted == 0) begin
            for (int p = 0; p < 3; p++) begin
                check_value($sformatf("wb[%0d].we", p), 32'(wb[p].we), 32'h0);
            end
        end
        // a held pair that fires during a flush still executes
        if (fire) begin
            execute_slot(m_pair.slot0, 0);
            execute_slot(m_pair.slot1, 1);
        end
        for (int p = 0; p < 3; p++) begin
            if (wb[p].we) begin
                match_write(p, wb[p]);
            end
        end
        if (flush) begin
            m_valid = 1'b0;
        end else if (acc) begin
            m_valid = 1'b1;
            m_pair  = in_pair;
        end else if (fire) begin
            m_valid = 1'b0;
        end
        if (acc) accepted++;
        took_pair = acc;
    endtask

    task automatic drive_inputs();
        if (accepted >= NUM_PAIRS) begin
            in_valid = 1'b0;
            flush    = 1'b0;
            ex_hold  = 1'b0;
        end else begin
            // an offered pair stays put until taken
            if (!(in_valid && !took_pair)) begin
                in_valid = (rand_bits(3) != 0);
                if (in_valid) in_pair = make_pair();
            end
            flush = (rand_bits(5) == 0);
            if (hold_left > 0) begin
                ex_hold = 1'b1;
                hold_left--;
            end else if (rand_bits(4) == 0) begin
                ex_hold   = 1'b1;
                hold_left = int'(rand_bits(2));
            end else begin
                ex_hold = 1'b0;
            end
        end
    endtask

    function automatic logic drained();
        return accepted >= NUM_PAIRS && !in_valid && !m_valid && exp_alu0.size() == 0 &&
               exp_alu1.size() == 0 && exp_load.size() == 0;
    endfunction

    initial begin
        lfsr_state   = 32'h9e1b_159a;
        aresetn      = 1'b0;
        flush        = 1'b0;
        ex_hold      = 1'b0;
        in_valid     = 1'b0;
        in_pair      = '0;
        m_valid      = 1'b0;
        m_pair       = '0;
        last_ld_rd   = '0;
        took_pair    = 1'b0;
        hold_left    = 0;
        accepted     = 0;
        value_errors = 0;
        other_errors = 0;
        for (int r = 0; r < `NUM_REGS; r++) m_regs[r] = '0;
        for (int w = 0; w < `SCRATCH_WORDS; w++) m_scratch[w] = '0;

        @(negedge clk);
        check_value("in_ready", 32'(in_ready), 32'h0);
        repeat (2) @(posedge clk);
        #1;
        aresetn = 1'b1;
        // first cycle out of reset still refuses pairs
        @(negedge clk);
        check_value("in_ready", 32'(in_ready), 32'h0);
        @(posedge clk);
        #1;
        drive_inputs();

        while (!drained()) begin
            @(negedge clk);
            process_cycle();
            @(posedge clk);
            #1;
            drive_inputs();
        end
        // idle tail catches late or duplicated writes
        repeat (4) begin
            @(negedge clk);
            process_cycle();
        end

        assert_fails = dut_i.reg_read_stage_i.props_i.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, other_errors, assert_fails);
        if (value_errors + other_errors + assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
